// ==== design/abus_cfg_pkg.sv ====
// ##########################################################################
// Memory configuration layouts
// ##########################################################################

package abus_cfg_pkg;

	// Bus width code
	// Bit 0 means 16-bit and bit 1 means 32-bit
	// Both bits set means 64-bit on a DRAM bank
	typedef logic [1:0] width_t;

	// Column count code for one DRAM bank
	typedef logic [1:0] colw_t;

	// memcon1 layout, bit 15 down to bit 0
	typedef struct packed {
		logic       spare_15;
		logic       cpu32;
		logic       nocpu;
		logic [1:0] io_spd;
		logic [2:0] spare_10_8;
		logic       fast_rom;
		logic [1:0] dram_spd;
		logic [1:0] rom_spd;
		width_t     rom_wid;
		logic       rom_hi;
	} memcon1_t;

	// memcon2 layout, bit 15 down to bit 0
	typedef struct packed {
		logic [1:0] spare_15_14;
		logic       hilo;
		logic       big_dram;
		// Refresh rate, kept in the layout but never stored
		logic [3:0] refresh;
		width_t     dwid1;
		colw_t      cols1;
		width_t     dwid0;
		colw_t      cols0;
	} memcon2_t;

	// One data bus word seen as either register
	typedef union packed {
		memcon1_t m1;
		memcon2_t m2;
	} memcon_word_t;

endpackage

// ==== design/abus_map_pkg.sv ====
// ##########################################################################
// Address map constants
// ##########################################################################

package abus_map_pkg;

	// Transfer address width
	localparam int ADDR_W = 24;

	typedef logic [ADDR_W-1:0] addr_t;

	// Decoded region of a memory request
	typedef enum logic [2:0] {
		RGN_NONE  = 3'd0,
		RGN_BOOT  = 3'd1,
		RGN_CART  = 3'd2,
		RGN_DRAM0 = 3'd3,
		RGN_DRAM1 = 3'd4
	} region_t;

	// Device window 100000 to 11FFFF
	// Only bits 20 to 17 are compared so it shows up at F00000 in ROM-high layout
	localparam addr_t DEV_BASE = 24'h100000;
	localparam int DEV_MSB = 20;
	localparam int DEV_LSB = 17;

	// 32-bit device sub-window 108000 to 10FFFF
	localparam addr_t DEV32_SPAN = 24'h108000;
	localparam int DEV32_LSB = 15;

	// Row address starts at bit 8 before the per-bank shift
	localparam int ROW_SHIFT_BASE = 8;

	// Multiplexed DRAM address width
	localparam int MA_W = 11;

endpackage

// ==== design/memcfg_if.sv ====
// ##########################################################################
// Configuration field bus
// ##########################################################################
`timescale 1ns/1ns

interface memcfg_if;
	import abus_cfg_pkg::*;

	// ROM layout and width
	logic   rom_hi;
	width_t rom_wid;
	// Per-bank DRAM geometry
	width_t dwid0;
	width_t dwid1;
	colw_t  cols0;
	colw_t  cols1;
	// Memory map configured
	logic   mset;

	modport regs (output rom_hi, rom_wid, dwid0, dwid1, cols0, cols1, mset);
	modport user (input rom_hi, rom_wid, dwid0, dwid1, cols0, cols1, mset);

endinterface

// ==== design/memcon_regs.sv ====
// ##########################################################################
// Memory configuration registers
// ##########################################################################
`timescale 1ns/1ns

module memcon_regs (
	input  logic        sys_clk,
	input  logic        resetl,
	input  logic        memc1w,
	input  logic        memc2w,
	input  logic        memc1r,
	input  logic        memc2r,
	input  logic [15:0] din,
	memcfg_if.regs      cfg,
	output logic [1:0]  rom_spd,
	output logic [1:0]  dram_spd,
	output logic [1:0]  io_spd,
	output logic        fast_rom,
	output logic        hilo,
	output logic [15:0] dout,
	output logic        dout_oe
);
	import abus_cfg_pkg::*;

	memcon_word_t din_w;
	memcon1_t     m1_wr;
	memcon2_t     m2_wr;
	memcon1_t     m1_q;
	memcon2_t     m2_q;
	logic         mset_q;

	assign din_w = din;

	// Keep only the live fields of an incoming word
	always_comb begin
		m1_wr = '0;
		m1_wr.rom_hi   = din_w.m1.rom_hi;
		m1_wr.rom_wid  = din_w.m1.rom_wid;
		m1_wr.rom_spd  = din_w.m1.rom_spd;
		m1_wr.dram_spd = din_w.m1.dram_spd;
		m1_wr.fast_rom = din_w.m1.fast_rom;
		m1_wr.io_spd   = din_w.m1.io_spd;
		m1_wr.nocpu    = din_w.m1.nocpu;
		m1_wr.cpu32    = din_w.m1.cpu32;
	end

	// Refresh and spare bits stay zero
	always_comb begin
		m2_wr = '0;
		m2_wr.cols0    = din_w.m2.cols0;
		m2_wr.dwid0    = din_w.m2.dwid0;
		m2_wr.cols1    = din_w.m2.cols1;
		m2_wr.dwid1    = din_w.m2.dwid1;
		m2_wr.big_dram = din_w.m2.big_dram;
		m2_wr.hilo     = din_w.m2.hilo;
	end

	// Register write, first memcon1 write marks the map as set
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			m1_q   <= '0;
			m2_q   <= '0;
			mset_q <= 1'b0;
		end else begin
			if (memc1w) begin
				m1_q   <= m1_wr;
				mset_q <= 1'b1;
			end
			if (memc2w)
				m2_q <= m2_wr;
		end
	end

	// Fields out to the decoders
	assign cfg.rom_hi  = m1_q.rom_hi;
	assign cfg.rom_wid = m1_q.rom_wid;
	assign cfg.dwid0   = m2_q.dwid0;
	assign cfg.dwid1   = m2_q.dwid1;
	assign cfg.cols0   = m2_q.cols0;
	assign cfg.cols1   = m2_q.cols1;
	assign cfg.mset    = mset_q;

	// Timing fields straight out
	assign rom_spd  = m1_q.rom_spd;
	assign dram_spd = m1_q.dram_spd;
	assign io_spd   = m1_q.io_spd;
	assign fast_rom = m1_q.fast_rom;
	assign hilo     = m2_q.hilo;

	// Readback bus, both reads together OR their words
	assign dout    = (memc1r ? m1_q : 16'h0000) | (memc2r ? m2_q : 16'h0000);
	assign dout_oe = memc1r | memc2r;

endmodule

// ==== design/region_decode.sv ====
// ##########################################################################
// Address map decode
// ##########################################################################
`timescale 1ns/1ns

module region_decode (
	input  abus_map_pkg::addr_t   t_addr,
	input  logic                  mreq,
	memcfg_if.user                cfg,
	output abus_map_pkg::region_t region,
	output logic                  from,
	output logic                  fdram,
	output abus_cfg_pkg::width_t  mw
);
	import abus_map_pkg::*;

	logic [2:0] seg;
	logic       in_dev;
	logic       in_dev32;
	region_t    map_rgn;

	// Top three address bits pick the 2 MB segment
	assign seg = t_addr[ADDR_W-1 -: 3];

	// Device windows, ignoring the upper bits
	assign in_dev   = (t_addr[DEV_MSB:DEV_LSB] == DEV_BASE[DEV_MSB:DEV_LSB]);
	assign in_dev32 = (t_addr[DEV_MSB:DEV32_LSB] == DEV32_SPAN[DEV_MSB:DEV32_LSB]);

	// Region by layout, before the request gate
	always_comb begin
		if (!cfg.mset) begin
			// Boot ROM everywhere until configured
			map_rgn = RGN_BOOT;
		end else if (!cfg.rom_hi) begin
			case (seg)
				3'b000:                 map_rgn = RGN_BOOT;
				3'b001, 3'b010, 3'b011: map_rgn = RGN_CART;
				3'b100, 3'b101:         map_rgn = RGN_DRAM1;
				default:                map_rgn = RGN_DRAM0;
			endcase
		end else begin
			case (seg)
				3'b000, 3'b001:         map_rgn = RGN_DRAM0;
				3'b010, 3'b011:         map_rgn = RGN_DRAM1;
				3'b100, 3'b101, 3'b110: map_rgn = RGN_CART;
				default:                map_rgn = RGN_BOOT;
			endcase
		end
	end

	// No request means no region
	assign region = mreq ? map_rgn : RGN_NONE;
	assign fdram  = (region == RGN_DRAM0) || (region == RGN_DRAM1);

	// ROM select for cartridge and boot outside the devices
	assign from = (map_rgn == RGN_CART) || ((map_rgn == RGN_BOOT) && !in_dev);

	// Width code of the addressed region
	always_comb begin
		case (map_rgn)
			RGN_BOOT:  mw = in_dev ? (in_dev32 ? 2'b10 : 2'b01) : cfg.rom_wid;
			RGN_CART:  mw = cfg.rom_wid;
			RGN_DRAM0: mw = cfg.dwid0;
			RGN_DRAM1: mw = cfg.dwid1;
			default:   mw = 2'b00;
		endcase
	end

endmodule

// ==== design/dram_addr_mux.sv ====
// ##########################################################################
// DRAM row and column address
// ##########################################################################
`timescale 1ns/1ns

module dram_addr_mux #(
	parameter int addr_w = abus_map_pkg::ADDR_W
) (
	input  logic                          sys_clk,
	input  logic                          resetl,
	input  logic [addr_w-1:0]             t_addr,
	input  logic                          bank1_sel,
	input  logic                          mux,
	memcfg_if.user                        cfg,
	output logic [abus_map_pkg::MA_W-1:0] row0,
	output logic [abus_map_pkg::MA_W-1:0] row1,
	output logic [abus_map_pkg::MA_W-1:0] ma
);
	import abus_map_pkg::*;

	logic [2:0]        cw0;
	logic [2:0]        cw1;
	logic [1:0]        sel_wid;
	logic [addr_w-1:0] col_sh;
	logic [MA_W-1:0]   col;

	// Row start for one bank
	function automatic logic [MA_W-1:0] row_of(input logic [addr_w-1:0] a,
		input logic [2:0] cw);
		logic [addr_w-1:0] sh;
		sh = a >> (ROW_SHIFT_BASE + cw);
		return sh[MA_W-1:0];
	endfunction

	// Row shift is column count plus data width
	assign cw0 = {1'b0, cfg.dwid0} + {1'b0, cfg.cols0};
	assign cw1 = {1'b0, cfg.dwid1} + {1'b0, cfg.cols1};

	assign row0 = row_of(t_addr, cw0);
	assign row1 = row_of(t_addr, cw1);

	// Column drops the byte lanes of the held bank
	assign sel_wid = bank1_sel ? cfg.dwid1 : cfg.dwid0;
	assign col_sh  = t_addr >> sel_wid;
	assign col     = col_sh[MA_W-1:0];

	// Mux high drives the row phase
	always_ff @(posedge sys_clk) begin
		if (!resetl)
			ma <= '0;
		else if (mux)
			ma <= bank1_sel ? row1 : row0;
		else
			ma <= col;
	end

endmodule

// ==== design/page_match.sv ====
// ##########################################################################
// Open row tracking
// ##########################################################################
`timescale 1ns/1ns

module page_match (
	input  logic                          sys_clk,
	input  logic                          resetl,
	input  logic [abus_map_pkg::MA_W-1:0] row0,
	input  logic [abus_map_pkg::MA_W-1:0] row1,
	input  logic                          load0,
	input  logic                          load1,
	input  logic                          clear,
	output logic                          hit0,
	output logic                          hit1
);
	import abus_map_pkg::*;

	logic [1:0][MA_W-1:0] cur_row;
	logic [1:0][MA_W-1:0] open_row;
	logic [1:0]           load;
	logic [1:0]           valid;

	assign cur_row = {row1, row0};
	assign load    = {load1, load0};

	// Row latched as the bank opens it
	always_ff @(posedge sys_clk) begin
		for (int b = 0; b < 2; b++) begin
			if (load[b])
				open_row[b] <= cur_row[b];
		end
	end

	// A load beats the row reset
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			valid <= '0;
		end else begin
			for (int b = 0; b < 2; b++) begin
				if (load[b])
					valid[b] <= 1'b1;
				else if (clear)
					valid[b] <= 1'b0;
			end
		end
	end

	// Same page when the open row equals the current one
	assign hit0 = valid[0] && (open_row[0] == row0);
	assign hit1 = valid[1] && (open_row[1] == row1);

endmodule

// ==== design/abus_ctrl.sv ====
// ##########################################################################
// Address bus control
// ##########################################################################
`timescale 1ns/1ns

module abus_ctrl #(
	parameter int addr_w = abus_map_pkg::ADDR_W
) (
	input  logic                  sys_clk,
	input  logic                  resetl,
	input  logic                  ack,
	input  logic [addr_w-1:0]     addr_in,
	input  logic                  newrow,
	input  logic                  resrow,
	input  abus_map_pkg::region_t region,
	input  logic                  hit0,
	input  logic                  hit1,
	output logic [addr_w-1:0]     t_addr,
	output logic [3:0]            bs,
	output logic                  dram,
	output logic                  bank1_sel,
	output logic                  load0,
	output logic                  load1,
	output logic                  clear,
	output logic                  match
);
	import abus_map_pkg::*;

	logic [addr_w-1:0] held_addr;

	// Live address during ack, last acked address otherwise
	assign t_addr = ack ? addr_in : held_addr;

	always_ff @(posedge sys_clk) begin
		if (!resetl)
			held_addr <= '0;
		else if (ack)
			held_addr <= addr_in;
	end

	// Bank select, bit order boot cart dram1 dram0
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			bs   <= 4'h0;
			dram <= 1'b0;
		end else if (ack) begin
			bs[0] <= (region == RGN_BOOT);
			bs[1] <= (region == RGN_CART);
			bs[2] <= (region == RGN_DRAM1);
			bs[3] <= (region == RGN_DRAM0);
			dram  <= (region == RGN_DRAM0) || (region == RGN_DRAM1);
		end
	end

	// Address mux follows the held bank
	assign bank1_sel = bs[2];

	// New row goes to the bank in cycle
	assign load0 = newrow & bs[3];
	assign load1 = newrow & bs[2];
	assign clear = resrow;

	// Page hit for the bank now addressed
	assign match = ((region == RGN_DRAM0) && hit0) || ((region == RGN_DRAM1) && hit1);

endmodule

// ==== design/abus_top.sv ====
// ##########################################################################
// Address bus controller
// ##########################################################################
`timescale 1ns/1ns

module abus_top #(
	parameter int addr_w = abus_map_pkg::ADDR_W
) (
	input  logic                          sys_clk,
	input  logic                          resetl,
	input  logic [addr_w-1:0]             addr_in,
	input  logic                          ack,
	input  logic                          mreq,
	input  logic                          mux,
	input  logic                          newrow,
	input  logic                          resrow,
	input  logic                          memc1w,
	input  logic                          memc2w,
	input  logic                          memc1r,
	input  logic                          memc2r,
	input  logic [15:0]                   din,
	output logic [abus_map_pkg::MA_W-1:0] ma,
	output logic [3:0]                    bs,
	output logic                          dram,
	output logic                          fdram,
	output logic                          from,
	output logic [1:0]                    mw,
	output logic                          match,
	output logic [1:0]                    rom_spd,
	output logic [1:0]                    dram_spd,
	output logic [1:0]                    io_spd,
	output logic                          fast_rom,
	output logic                          hilo,
	output logic [15:0]                   dout,
	output logic                          dout_oe
);
	import abus_map_pkg::*;

	logic [addr_w-1:0] t_addr;
	region_t           region;
	logic              bank1_sel;
	logic [MA_W-1:0]   row0;
	logic [MA_W-1:0]   row1;
	logic              load0;
	logic              load1;
	logic              clear;
	logic              hit0;
	logic              hit1;

	// Configuration fields shared by the decoders
	memcfg_if cfg_bus ();

	memcon_regs u_regs (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.memc1w  (memc1w),
		.memc2w  (memc2w),
		.memc1r  (memc1r),
		.memc2r  (memc2r),
		.din     (din),
		.cfg     (cfg_bus.regs),
		.rom_spd (rom_spd),
		.dram_spd(dram_spd),
		.io_spd  (io_spd),
		.fast_rom(fast_rom),
		.hilo    (hilo),
		.dout    (dout),
		.dout_oe (dout_oe)
	);

	region_decode u_decode (
		.t_addr(t_addr),
		.mreq  (mreq),
		.cfg   (cfg_bus.user),
		.region(region),
		.from  (from),
		.fdram (fdram),
		.mw    (mw)
	);

	dram_addr_mux #(.addr_w(addr_w)) u_amux (
		.sys_clk  (sys_clk),
		.resetl   (resetl),
		.t_addr   (t_addr),
		.bank1_sel(bank1_sel),
		.mux      (mux),
		.cfg      (cfg_bus.user),
		.row0     (row0),
		.row1     (row1),
		.ma       (ma)
	);

	page_match u_page (
		.sys_clk(sys_clk),
		.resetl (resetl),
		.row0   (row0),
		.row1   (row1),
		.load0  (load0),
		.load1  (load1),
		.clear  (clear),
		.hit0   (hit0),
		.hit1   (hit1)
	);

	abus_ctrl #(.addr_w(addr_w)) u_ctrl (
		.sys_clk  (sys_clk),
		.resetl   (resetl),
		.ack      (ack),
		.addr_in  (addr_in),
		.newrow   (newrow),
		.resrow   (resrow),
		.region   (region),
		.hit0     (hit0),
		.hit1     (hit1),
		.t_addr   (t_addr),
		.bs       (bs),
		.dram     (dram),
		.bank1_sel(bank1_sel),
		.load0    (load0),
		.load1    (load1),
		.clear    (clear),
		.match    (match)
	);

endmodule

// ==== bench/tb_abus.sv ====
// ##########################################################################
// Address bus controller testbench
// ##########################################################################
`timescale 1ns/1ns

module tb_abus;
	import abus_cfg_pkg::*;
	import abus_map_pkg::*;

	// Phase lengths in clock cycles
	localparam int RESET_CYCLES = 8;
	localparam int PRE_CYCLES   = 32;
	localparam int MAIN_CYCLES  = 300;
	localparam int MID_RESET    = 2;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + PRE_CYCLES + 2 * MAIN_CYCLES + MID_RESET + 50;
	// Bits that survive a register write
	localparam logic [15:0] M1_LIVE = 16'h78ff;
	localparam logic [15:0] M2_LIVE = 16'h30ff;

	logic              sys_clk;
	logic              resetl;
	logic [ADDR_W-1:0] addr_in;
	logic              ack, mreq, mux, newrow, resrow;
	logic              memc1w, memc2w, memc1r, memc2r;
	logic [15:0]       din;
	logic [MA_W-1:0]   ma;
	logic [3:0]        bs;
	logic              dram, fdram, from, match, fast_rom, hilo, dout_oe;
	logic [1:0]        mw, rom_spd, dram_spd, io_spd;
	logic [15:0]       dout;

	// Reference model state
	memcon_word_t      m1_m;
	memcon_word_t      m2_m;
	logic              mset_m;
	logic [ADDR_W-1:0] held_m;
	logic [ADDR_W-1:0] base;
	logic [3:0]        bs_m;
	logic              dram_m;
	logic [MA_W-1:0]   ma_m;
	logic [MA_W-1:0]   open_m [2];
	logic [1:0]        valid_m;
	logic              model_live;

	integer seed;
	int     error_count, check_count, hit_count, cycles;

	abus_top #(.addr_w(ADDR_W)) dut0 (.*);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// Hard stop in case the stimulus never finishes
	initial begin
		cycles = 0;
		while (cycles <= CYCLE_LIMIT) begin
			@(posedge sys_clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the stimulus did not finish", cycles);
		$display("Test failures found");
		$finish;
	end

	// Device window 100000 to 11FFFF and its mirror at F00000
	function automatic logic dev_win(input logic [ADDR_W-1:0] a);
		return (a & 24'h1e0000) == 24'h100000;
	endfunction

	function automatic logic dev32_win(input logic [ADDR_W-1:0] a);
		return (a & 24'h1f8000) == 24'h108000;
	endfunction

	// Map by address range without the mreq gate
	function automatic region_t map_region(input logic [ADDR_W-1:0] a);
		if (!mset_m)
			return RGN_BOOT;
		else if (!m1_m.m1.rom_hi)
			return (a < 24'h200000) ? RGN_BOOT : (a < 24'h800000) ? RGN_CART :
				(a < 24'hc00000) ? RGN_DRAM1 : RGN_DRAM0;
		else
			return (a < 24'h400000) ? RGN_DRAM0 : (a < 24'h800000) ? RGN_DRAM1 :
				(a < 24'he00000) ? RGN_CART : RGN_BOOT;
	endfunction

	function automatic width_t exp_width(input logic [ADDR_W-1:0] a);
		case (map_region(a))
			RGN_BOOT:  return dev_win(a) ? (dev32_win(a) ? 2'b10 : 2'b01) : m1_m.m1.rom_wid;
			RGN_CART:  return m1_m.m1.rom_wid;
			RGN_DRAM0: return m2_m.m2.dwid0;
			default:   return m2_m.m2.dwid1;
		endcase
	endfunction

	// Row is the address above 8 plus column count plus width
	function automatic logic [MA_W-1:0] row_addr(input logic [ADDR_W-1:0] a,
		input logic [1:0] cols, input logic [1:0] wid);
		logic [ADDR_W-1:0] sh;
		sh = a >> (ROW_SHIFT_BASE + int'(cols) + int'(wid));
		return sh[MA_W-1:0];
	endfunction

	function automatic logic [MA_W-1:0] col_addr(input logic [ADDR_W-1:0] a,
		input logic [1:0] wid);
		logic [ADDR_W-1:0] sh;
		sh = a >> wid;
		return sh[MA_W-1:0];
	endfunction

	task automatic compare_out(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		check_count++;
		assert (got === exp) else begin
			error_count++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	// Outputs against the model at mid cycle
	task automatic check_outputs();
		logic [ADDR_W-1:0] t;
		region_t           mr;
		region_t           rg;
		logic              exp_match;
		t  = ack ? addr_in : held_m;
		mr = map_region(t);
		rg = mreq ? mr : RGN_NONE;
		exp_match = (rg == RGN_DRAM0 && valid_m[0] &&
			open_m[0] == row_addr(t, m2_m.m2.cols0, m2_m.m2.dwid0)) ||
			(rg == RGN_DRAM1 && valid_m[1] &&
			open_m[1] == row_addr(t, m2_m.m2.cols1, m2_m.m2.dwid1));
		compare_out("bs", 16'(bs), 16'(bs_m));
		compare_out("dram", 16'(dram), 16'(dram_m));
		compare_out("ma", 16'(ma), 16'(ma_m));
		compare_out("fdram", 16'(fdram), 16'(rg == RGN_DRAM0 || rg == RGN_DRAM1));
		compare_out("from", 16'(from), 16'(mr == RGN_CART || (mr == RGN_BOOT && !dev_win(t))));
		compare_out("mw", 16'(mw), 16'(exp_width(t)));
		compare_out("match", 16'(match), 16'(exp_match));
		compare_out("rom_spd", 16'(rom_spd), 16'(m1_m.m1.rom_spd));
		compare_out("dram_spd", 16'(dram_spd), 16'(m1_m.m1.dram_spd));
		compare_out("io_spd", 16'(io_spd), 16'(m1_m.m1.io_spd));
		compare_out("fast_rom", 16'(fast_rom), 16'(m1_m.m1.fast_rom));
		compare_out("hilo", 16'(hilo), 16'(m2_m.m2.hilo));
		compare_out("dout", dout, (memc1r ? 16'(m1_m) : 16'h0) | (memc2r ? 16'(m2_m) : 16'h0));
		compare_out("dout_oe", 16'(dout_oe), 16'(memc1r | memc2r));
		if (exp_match && match)
			hit_count++;
	endtask

	// Model state at the rising edge from the old state
	task automatic model_clock();
		logic [ADDR_W-1:0] t;
		region_t           rg;
		logic [MA_W-1:0]   r0, r1;
		if (!resetl) begin
			m1_m    = '0;
			m2_m    = '0;
			mset_m  = 1'b0;
			held_m  = '0;
			bs_m    = 4'h0;
			dram_m  = 1'b0;
			ma_m    = '0;
			valid_m = 2'b00;
			model_live = 1'b1;
		end else begin
			t  = ack ? addr_in : held_m;
			rg = mreq ? map_region(t) : RGN_NONE;
			r0 = row_addr(t, m2_m.m2.cols0, m2_m.m2.dwid0);
			r1 = row_addr(t, m2_m.m2.cols1, m2_m.m2.dwid1);
			if (mux)
				ma_m = bs_m[2] ? r1 : r0;
			else
				ma_m = col_addr(t, bs_m[2] ? m2_m.m2.dwid1 : m2_m.m2.dwid0);
			// New row wins over row reset
			if (newrow && bs_m[3]) begin
				open_m[0]  = r0;
				valid_m[0] = 1'b1;
			end else if (resrow) begin
				valid_m[0] = 1'b0;
			end
			if (newrow && bs_m[2]) begin
				open_m[1]  = r1;
				valid_m[1] = 1'b1;
			end else if (resrow) begin
				valid_m[1] = 1'b0;
			end
			if (ack) begin
				held_m = addr_in;
				bs_m   = {rg == RGN_DRAM0, rg == RGN_DRAM1, rg == RGN_CART, rg == RGN_BOOT};
				dram_m = (rg == RGN_DRAM0) || (rg == RGN_DRAM1);
			end
			if (memc1w) begin
				m1_m   = din & M1_LIVE;
				mset_m = 1'b1;
			end
			if (memc2w)
				m2_m = din & M2_LIVE;
		end
	endtask

	// Check at the falling edge and clock the model at the rising edge
	task automatic run_cycle();
		@(negedge sys_clk);
		if (model_live)
			check_outputs();
		@(posedge sys_clk);
		model_clock();
		#2;
	endtask

	// Addresses mostly stay on one 256 byte page so rows repeat
	task automatic drive_random(input logic allow_m1w);
		logic [31:0] r;
		logic [31:0] r2;
		r  = $random(seed);
		r2 = $random(seed);
		if (r[1:0] == 2'b00) begin
			base = r2[ADDR_W-1:0];
			// Some pages land in the device window or its mirror
			if (r2[26:25] == 2'b00)
				base[ADDR_W-1:17] = r2[24] ? 7'h78 : 7'h08;
		end
		addr_in = {base[ADDR_W-1:8], r[9:2]};
		ack     = r[10];
		mreq    = r[13:11] != 3'b000;
		mux     = r[14];
		newrow  = r[17:15] == 3'b000;
		resrow  = r[21:18] == 4'b0000;
		memc1w  = allow_m1w && (r[25:22] == 4'b0000);
		memc2w  = r[29:26] == 4'b0000;
		memc1r  = r[30];
		memc2r  = r[31];
		din     = r2[31:16];
	endtask

	// First cycle writes memcon1 so the map is set
	task automatic main_phase();
		drive_random(1'b1);
		memc1w = 1'b1;
		run_cycle();
		repeat (MAIN_CYCLES - 1) begin
			drive_random(1'b1);
			run_cycle();
		end
	endtask

	initial begin
		seed        = 32'heeca;
		error_count = 0;
		check_count = 0;
		hit_count   = 0;
		model_live  = 1'b0;
		base        = '0;
		resetl      = 1'b0;
		addr_in     = '0;
		{ack, mreq, mux, newrow, resrow} = 5'b00000;
		{memc1w, memc2w, memc1r, memc2r} = 4'b0000;
		din = 16'h0000;
		// Start from the first clock edge
		@(posedge sys_clk);
		repeat (RESET_CYCLES) run_cycle();
		resetl = 1'b1;
		// Boot only traffic before any memcon1 write
		repeat (PRE_CYCLES) begin
			drive_random(1'b0);
			run_cycle();
		end
		main_phase();
		resetl = 1'b0;
		repeat (MID_RESET) begin
			drive_random(1'b0);
			run_cycle();
		end
		resetl = 1'b1;
		main_phase();
		if (hit_count == 0) begin
			error_count++;
			$display("match never went high on a stored row, page hits were not exercised");
		end
		$display("Checks: %0d, errors: %0d, page hits: %0d", check_count, error_count, hit_count);
		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== sim.f ====
design/abus_cfg_pkg.sv
design/abus_map_pkg.sv
design/memcfg_if.sv
design/memcon_regs.sv
design/region_decode.sv
design/dram_addr_mux.sv
design/page_match.sv
design/abus_ctrl.sv
design/abus_top.sv
bench/tb_abus.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the address bus controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_abus -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_abus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
	exit 0
else
	exit 1
fi
